// ==== hdl/bitstream_unpacker.sv ====
// producer of the data path
// takes 32-bit words from the bitstream source and hands them on as symbols,
// least significant byte first, using the ready/read strobe pair on both sides
// a word is loaded one cycle before its first symbol shows as ready
`timescale 1ns/1ps
`include "pr_cfg.svh"

module bitstream_unpacker import pr_pkg::*; (
	input  logic       data_clk,
	input  logic       reset,
	input  logic       data_request,
	input  pr_word_t   src_word,
	input  logic       src_ready,
	output logic       src_read,
	output pr_symbol_t sym_data,
	output logic       sym_ready,
	input  logic       sym_read
);

	// enough bits to index every symbol of a word
	localparam int IDX_WIDTH = $clog2(`PR_SYMBOLS_PER_WORD);

	// the word being unpacked, payload only
	pr_word_t word_reg;

	// position of the symbol currently on offer
	logic [IDX_WIDTH-1:0] index;

	// set while word_reg holds symbols that have not been read yet
	logic full;

	// high when the symbol on offer is the last one of the word
	logic last_symbol;

	// the downstream read takes the last symbol in this cycle
	logic last_taken;

	assign last_symbol = (index == IDX_WIDTH'(`PR_SYMBOLS_PER_WORD - 1));
	assign last_taken = sym_read & last_symbol;

	// take a new word when nothing is held or the held word is being emptied,
	// so a back to back word follows its predecessor without a gap
	// outside a session the source is never read
	assign src_read = data_request & src_ready & (~full | last_taken);

	// the symbol on offer is a plain byte select from the held word
	assign sym_data = word_reg[index * `PR_SYMBOL_WIDTH +: `PR_SYMBOL_WIDTH];

	// ready drops at once when the session ends, the flag itself clears on the edge
	assign sym_ready = full & data_request;

	// word storage, loaded only on an accepted source read
	always_ff @(posedge data_clk) begin
		if (src_read) begin
			word_reg <= src_word;
		end
	end

	// fill flag and symbol index
	always_ff @(posedge data_clk) begin
		if (reset || !data_request) begin
			// a partly used word is thrown away when the session ends
			full <= 1'b0;
			index <= '0;
		end else if (src_read) begin
			// a fresh word always starts again at byte 0
			full <= 1'b1;
			index <= '0;
		end else if (sym_read) begin
			if (last_symbol) begin
				// word used up and no replacement was ready
				full <= 1'b0;
				index <= '0;
			end else begin
				index <= index + 1'b1;
			end
		end
	end

	// the source strobe must only ever answer an offered word
	a_src_read_needs_ready: assert property (
		@(posedge data_clk) disable iff (reset)
		src_read |-> src_ready
	);

	// a read from downstream must never pull from an empty unpacker,
	// which would hand out a stale byte of the previous word
	a_sym_read_needs_data: assert property (
		@(posedge data_clk) disable iff (reset)
		sym_read |-> full
	);

endmodule

// ==== hdl/pr_config_sink.sv ====
// consumer of the data path
// presents symbols from the holding stage to the reconfiguration port and
// follows the port's back-pressure without adding latency
// it keeps a running sum and a count of the symbols delivered in the session
// and raises pr_done for one cycle once image_symbols symbols have gone out
`timescale 1ns/1ps
`include "pr_cfg.svh"

module pr_config_sink import pr_pkg::*; (
	input  logic       data_clk,
	input  logic       reset,
	input  logic       data_request,
	input  pr_count_t  image_symbols,
	input  pr_symbol_t in_data,
	input  logic       in_ready,
	output logic       in_read,
	output pr_symbol_t pr_data,
	output logic       pr_valid,
	input  logic       pr_ready,
	output pr_sum_t    pr_sum,
	output logic       pr_done
);

	// symbols delivered so far in this session
	pr_count_t count;

	// running sum, wraps on overflow
	pr_sum_t sum;

	// set once the image length has been reached in this session
	logic complete;

	// high on each cycle in which a symbol goes to the port
	logic deliver;

	// count including the symbol delivered in this cycle
	pr_count_t count_next;

	// the symbol widened to the sum width
	pr_sum_t sym_ext;

	// port side follows the stage directly, no register in between
	assign pr_data = in_data;
	assign pr_valid = in_ready & data_request;

	// a delivery is also the read strobe back to the stage
	assign deliver = pr_valid & pr_ready;
	assign in_read = deliver;

	assign count_next = count + 1'b1;
	assign sym_ext = {{(`PR_SUM_WIDTH - `PR_SYMBOL_WIDTH){1'b0}}, in_data};

	assign pr_sum = sum;

	// session statistics and completion
	always_ff @(posedge data_clk) begin
		if (reset || !data_request) begin
			count <= '0;
			sum <= '0;
			complete <= 1'b0;
			pr_done <= 1'b0;
		end else begin
			// done is a single cycle pulse by default
			pr_done <= 1'b0;
			if (deliver) begin
				count <= count_next;
				sum <= sum + sym_ext;
				// the complete flag keeps a counter wrap from firing a second time
				if (!complete && (count_next == image_symbols)) begin
					complete <= 1'b1;
					pr_done <= 1'b1;
				end
			end
		end
	end

	// completion is a single cycle pulse
	a_done_single_cycle: assert property (
		@(posedge data_clk) disable iff (reset)
		pr_done |=> !pr_done
	);

	// the port must keep its symbol while it is stalled, and the stage behind
	// the sink is what guarantees that
	a_port_data_stable: assert property (
		@(posedge data_clk) disable iff (reset)
		(pr_valid && !pr_ready) |=> (!data_request || $stable(pr_data))
	);

endmodule

// ==== hdl/pr_data_path.sv ====
// top level of the partial-reconfiguration bitstream data path
// source words are split into symbols by the unpacker, pass the one-entry
// holding stage and are presented to the reconfiguration port by the sink
// with an empty path and a ready port a word reaches pr_valid two cycles
// after it is read, and after that one symbol per cycle goes out
// data_request frames one session, dropping it empties every stage
`timescale 1ns/1ps
`include "pr_cfg.svh"

module pr_data_path import pr_pkg::*; (
	input  logic       data_clk,
	input  logic       reset,
	input  logic       data_request,
	input  pr_count_t  image_symbols,
	input  pr_word_t   src_word,
	input  logic       src_ready,
	output logic       src_read,
	output pr_symbol_t pr_data,
	output logic       pr_valid,
	input  logic       pr_ready,
	output pr_sum_t    pr_sum,
	output logic       pr_done
);

	// unpacker to holding stage
	pr_symbol_t sym_data;
	logic       sym_ready;
	logic       sym_read;

	// holding stage to sink
	pr_symbol_t stage_data;
	logic       stage_ready;
	logic       stage_read;

	bitstream_unpacker u_unpacker (
		.data_clk     (data_clk),
		.reset        (reset),
		.data_request (data_request),
		.src_word     (src_word),
		.src_ready    (src_ready),
		.src_read     (src_read),
		.sym_data     (sym_data),
		.sym_ready    (sym_ready),
		.sym_read     (sym_read)
	);

	// the single cycle of buffering in the path lives here
	pr_data_stage u_stage (
		.data_clk       (data_clk),
		.reset          (reset),
		.data_request   (data_request),
		.data_in        (sym_data),
		.data_in_ready  (sym_ready),
		.data_in_read   (sym_read),
		.data_out       (stage_data),
		.data_out_ready (stage_ready),
		.data_out_read  (stage_read)
	);

	pr_config_sink u_sink (
		.data_clk      (data_clk),
		.reset         (reset),
		.data_request  (data_request),
		.image_symbols (image_symbols),
		.in_data       (stage_data),
		.in_ready      (stage_ready),
		.in_read       (stage_read),
		.pr_data       (pr_data),
		.pr_valid      (pr_valid),
		.pr_ready      (pr_ready),
		.pr_sum        (pr_sum),
		.pr_done       (pr_done)
	);

endmodule

// ==== hdl/pr_data_stage.sv ====
// one-entry holding stage between the unpacker and the configuration sink
// a symbol read from the input on one edge is offered on the output after it
// input is taken whenever the stage is empty or its output is read in the same
// cycle, so a steady stream passes at one symbol per cycle
`timescale 1ns/1ps
`include "pr_cfg.svh"

module pr_data_stage import pr_pkg::*; (
	input  logic       data_clk,
	input  logic       reset,
	input  logic       data_request,
	input  pr_symbol_t data_in,
	input  logic       data_in_ready,
	output logic       data_in_read,
	output pr_symbol_t data_out,
	output logic       data_out_ready,
	input  logic       data_out_read
);

	// read upstream when there is room now or room is being made this cycle
	assign data_in_read = data_request & data_in_ready & (~data_out_ready | data_out_read);

	// the holding register is only written on an accepted input read
	always_ff @(posedge data_clk) begin
		if (data_in_read) begin
			data_out <= data_in;
		end
	end

	// ready flag of the held symbol
	always_ff @(posedge data_clk) begin
		if (reset || !data_request) begin
			data_out_ready <= 1'b0;
		end else if (data_out_ready) begin
			// within a session the flag only goes down when the held symbol
			// leaves and nothing replaces it
			if (data_out_read && !data_in_ready) begin
				data_out_ready <= 1'b0;
			end
		end else if (data_in_ready) begin
			// empty stage takes the offered symbol
			data_out_ready <= 1'b1;
		end
	end

	// once the session has ended the stage must not offer anything
	a_no_ready_outside_session: assert property (
		@(posedge data_clk) disable iff (reset)
		!data_request |=> !data_out_ready
	);

endmodule

// ==== hdl/pr_pkg.sv ====
// shared data types of the partial-reconfiguration data path
// every module imports this package with a wildcard import in its header
// the sizes come from the config header so that both stay in step
`include "pr_cfg.svh"

package pr_pkg;

	// a complete word from the bitstream source
	typedef logic [`PR_WORD_WIDTH-1:0] pr_word_t;

	// one symbol handed from stage to stage and out to the port
	typedef logic [`PR_SYMBOL_WIDTH-1:0] pr_symbol_t;

	// running sum of delivered symbols
	// additions simply wrap at the type width
	typedef logic [`PR_SUM_WIDTH-1:0] pr_sum_t;

	// a number of symbols, used for the image length and delivery count
	typedef logic [`PR_COUNT_WIDTH-1:0] pr_count_t;

endpackage

// ==== include/pr_cfg.svh ====
// width settings for the partial-reconfiguration bitstream data path
// include this wherever the word, symbol, sum or count sizes are needed
// the package builds its shared types from these values
`ifndef PR_CFG_SVH
`define PR_CFG_SVH

// one word as it arrives from the bitstream source
`define PR_WORD_WIDTH 32

// one symbol as it is presented to the reconfiguration port
`define PR_SYMBOL_WIDTH 8

// symbols carried by one source word, least significant byte goes first
`define PR_SYMBOLS_PER_WORD 4

// running sum of delivered symbols, wraps modulo two to this power
`define PR_SUM_WIDTH 16

// symbol counters, wide enough for a full image of about one million symbols
`define PR_COUNT_WIDTH 20

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the data path testbench with Verilator and runs it
# the run counts as passed only when the log holds the pass line
set -e
set -o pipefail

cd "$(dirname "$0")"

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_pr_data_path -o tb_pr_data_path -f sim.f

./obj_dir/tb_pr_data_path | tee "$log_file"

if grep -qx "all tests passed" "$log_file"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== sim.f ====
+incdir+include
hdl/pr_pkg.sv
hdl/bitstream_unpacker.sv
hdl/pr_data_stage.sv
hdl/pr_config_sink.sv
hdl/pr_data_path.sv
tests/tb_pr_data_path.sv

// ==== tests/tb_pr_data_path.sv ====
// testbench for the partial-reconfiguration bitstream data path
// a random word source and a random port model drive the DUT, a reference
// model keeps the expected byte stream, sum and delivery count, and
// concurrent assertions compare the port side of the DUT against it
// sessions cover full images, aborted images and gapless streaming runs
`timescale 1ns/1ps
`include "pr_cfg.svh"

module tb_pr_data_path import pr_pkg::*; ();

	// DUT ports and the source and port inputs that drive them
	logic       data_clk;
	logic       reset;
	logic       data_request;
	pr_count_t  image_symbols;
	pr_word_t   src_word = '0;
	logic       src_ready = 1'b0;
	logic       src_read;
	pr_symbol_t pr_data;
	logic       pr_valid;
	logic       pr_ready = 1'b0;
	pr_sum_t    pr_sum;
	logic       pr_done;

	// source always ready and port always ready while this is set
	logic stream_mode;

	// the running session is expected to reach image_symbols
	logic expect_done;

	// reference model state, updated once per clock edge
	pr_symbol_t byte_q[$];
	logic       exp_have;
	pr_symbol_t exp_head;
	pr_sum_t    exp_sum;
	pr_count_t  exp_count;
	int         done_count;
	logic       got_word;
	logic       got_delivery;

	// a symbol leaves the DUT on this edge
	logic deliver;

	// the first source word of the session is accepted on this edge
	logic first_take;

	int   err_count = 0;
	logic timed_out;

	initial begin
		data_clk = 1'b0;
		forever #4 data_clk = ~data_clk;
	end

	pr_data_path uut (
		.data_clk      (data_clk),
		.reset         (reset),
		.data_request  (data_request),
		.image_symbols (image_symbols),
		.src_word      (src_word),
		.src_ready     (src_ready),
		.src_read      (src_read),
		.pr_data       (pr_data),
		.pr_valid      (pr_valid),
		.pr_ready      (pr_ready),
		.pr_sum        (pr_sum),
		.pr_done       (pr_done)
	);

	assign deliver = data_request & pr_valid & pr_ready;
	assign first_take = data_request & src_read & src_ready & ~got_word;

	// source model keeps an offered word until it is read, then offers
	// a new random word or leaves a random gap
	always @(posedge data_clk) begin
		if (!src_ready || src_read) begin
			if (stream_mode || (($urandom % 4) != 0)) begin
				src_ready <= 1'b1;
				src_word <= $urandom;
			end else begin
				src_ready <= 1'b0;
			end
		end
	end

	// port model stalls at random unless streaming
	always @(posedge data_clk) begin
		pr_ready <= stream_mode ? 1'b1 : (($urandom % 3) != 0);
	end

	// in the reference model every accepted word adds its bytes lsb first
	// and every delivery takes the oldest byte and adds it to the sum
	always @(posedge data_clk) begin
		int k;
		if (reset || !data_request) begin
			// session end throws away whatever the path still held
			byte_q.delete();
			exp_sum = '0;
			exp_count = '0;
			done_count = 0;
			got_word = 1'b0;
			got_delivery = 1'b0;
		end else begin
			if (deliver) begin
				if (byte_q.size() > 0) begin
					exp_sum = exp_sum + pr_sum_t'(byte_q[0]);
					void'(byte_q.pop_front());
				end
				exp_count = exp_count + 1'b1;
				got_delivery = 1'b1;
			end
			if (pr_done) begin
				done_count = done_count + 1;
			end
			if (src_read && src_ready) begin
				for (k = 0; k < `PR_SYMBOLS_PER_WORD; k++) begin
					byte_q.push_back(src_word[k * `PR_SYMBOL_WIDTH +: `PR_SYMBOL_WIDTH]);
				end
				got_word = 1'b1;
			end
		end
		exp_have = (byte_q.size() > 0);
		exp_head = exp_have ? byte_q[0] : '0;
	end

	// a delivery must have an accepted byte behind it, otherwise it is a duplicate
	a_no_extra_delivery: assert property (
		@(posedge data_clk) disable iff (reset)
		deliver |-> exp_have
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: the port took a symbol that no accepted word supplied", $time);
	end

	// bytes come out in source order and a lost byte shows up as a mismatch
	a_data_order: assert property (
		@(posedge data_clk) disable iff (reset)
		(deliver && exp_have) |-> (pr_data == exp_head)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: pr_data is %02h, expected %02h",
			$time, $sampled(pr_data), $sampled(exp_head));
	end

	a_sum_at_done: assert property (
		@(posedge data_clk) disable iff (reset)
		pr_done |-> (pr_sum == exp_sum)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: pr_sum is %04h at pr_done, expected %04h",
			$time, $sampled(pr_sum), $sampled(exp_sum));
	end

	// the delivery that reaches the image length is followed by pr_done
	a_done_after_count: assert property (
		@(posedge data_clk) disable iff (reset)
		(deliver && ((exp_count + 1'b1) == image_symbols)) |=> pr_done
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: pr_done did not follow the last symbol of the image", $time);
	end

	a_done_once: assert property (
		@(posedge data_clk) disable iff (reset)
		pr_done |-> (done_count == 0 && exp_count == image_symbols)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: pr_done pulsed without the image length just reached", $time);
	end

	// a full session ends with exactly one completion pulse behind it
	a_done_per_session: assert property (
		@(posedge data_clk) disable iff (reset)
		(expect_done && $fell(data_request)) |-> (done_count == 1)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: session ended with %0d pr_done pulses, expected 1",
			$time, $sampled(done_count));
	end

	// outside a session nothing is read or offered
	a_idle_outputs: assert property (
		@(posedge data_clk) disable iff (reset)
		!data_request |-> (!src_read && !pr_valid)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: src_read or pr_valid was high outside a session", $time);
	end

	a_idle_cleared: assert property (
		@(posedge data_clk) disable iff (reset)
		!data_request |=> (pr_sum == '0 && !pr_done)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: pr_sum %04h or pr_done %0b not cleared after session end",
			$time, $sampled(pr_sum), $sampled(pr_done));
	end

	// with no stall anywhere the port sees one symbol on every cycle
	a_stream_gapless: assert property (
		@(posedge data_clk) disable iff (reset)
		(stream_mode && deliver) |=> (!data_request || pr_valid)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: pr_valid dropped during a stall-free stream", $time);
	end

	// an empty path brings the first word to the port two cycles after its read
	a_stream_latency: assert property (
		@(posedge data_clk) disable iff (reset)
		(stream_mode && data_request && pr_valid && !got_delivery) |-> $past(first_take, 2)
	) else begin
		err_count = err_count + 1;
		$display("ERR %0t: first pr_valid did not come two cycles after the first read",
			$time);
	end

	task automatic wait_cycles(input int cycles);
		repeat (cycles) @(posedge data_clk);
	endtask

	// sets up the next session while data_request is low, then raises it
	task automatic start_session(input pr_count_t symbols, input logic stream,
		input logic full_image);
		@(posedge data_clk);
		image_symbols <= symbols;
		stream_mode <= stream;
		expect_done <= full_image;
		// let the source and port models settle into the new mode
		wait_cycles(6);
		data_request <= 1'b1;
	endtask

	task automatic end_session();
		@(posedge data_clk);
		data_request <= 1'b0;
		wait_cycles(4);
	endtask

	task automatic wait_for_done(input int limit);
		int waited;
		waited = 0;
		while (!timed_out) begin
			@(posedge data_clk);
			if (pr_done) begin
				break;
			end
			waited = waited + 1;
			if (waited >= limit) begin
				$display("timed out after %0d cycles waiting for pr_done", limit);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_for_deliveries(input int symbols, input int limit);
		int waited;
		int seen;
		waited = 0;
		seen = 0;
		while (!timed_out && seen < symbols) begin
			@(posedge data_clk);
			if (deliver) begin
				seen = seen + 1;
			end
			waited = waited + 1;
			if (seen < symbols && waited >= limit) begin
				$display("timed out after %0d cycles with %0d of %0d symbols delivered",
					limit, seen, symbols);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic run_sessions();
		// the source offers words while no session is open
		wait_cycles(20);

		// full image under random gaps and stalls
		start_session(20'd200, 1'b0, 1'b1);
		wait_for_done(4000);
		if (timed_out) return;
		wait_cycles(12);
		end_session();

		// an abort in the middle of a word is followed by a fresh image
		start_session(20'd400, 1'b0, 1'b0);
		wait_for_deliveries(57, 4000);
		if (timed_out) return;
		end_session();
		start_session(20'd100, 1'b0, 1'b1);
		wait_for_done(2000);
		if (timed_out) return;
		wait_cycles(12);
		end_session();

		// a stall-free stream is followed by an aborted one
		start_session(20'd64, 1'b1, 1'b1);
		wait_for_done(200);
		if (timed_out) return;
		wait_cycles(8);
		end_session();
		start_session(20'd300, 1'b1, 1'b0);
		wait_for_deliveries(21, 200);
		if (timed_out) return;
		end_session();

		// back to random traffic after the stream was cut short
		start_session(20'd150, 1'b0, 1'b1);
		wait_for_done(3000);
		if (timed_out) return;
		wait_cycles(12);
		end_session();
	endtask

	initial begin
		void'($urandom(32'h878));
		timed_out = 1'b0;
		reset <= 1'b1;
		data_request <= 1'b0;
		image_symbols <= '0;
		stream_mode <= 1'b0;
		expect_done <= 1'b0;
		repeat (16) @(posedge data_clk);
		reset <= 1'b0;
		run_sessions();
		$display("run ended with %0d errors and %0d timeouts", err_count, timed_out);
		if (err_count == 0 && !timed_out) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
